//--- src/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  // ieee single precision fields
  localparam int FLOAT_W  = 32;
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int EXP_BIAS = 127;

  // unit stages between issue and retire, same as the addsub structure
  localparam int PIPE_DEPTH = 3;

  // issue register, unit stages, retire register
  localparam int LATENCY = PIPE_DEPTH + 2;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_CMP = 2'd3
  } fpu_op_t;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;  // stored bits, hidden one implied
  } float_t;

endpackage

`default_nettype wire

//--- src/fp_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fp_issue_if;
  import fpu_pkg::*;

  logic    valid;  // one cycle per accepted start
  fpu_op_t op;
  float_t  a;
  float_t  b;

  modport issue (
    output valid,
    output op,
    output a,
    output b
  );

  modport unit (
    input valid,
    input op,
    input a,
    input b
  );

endinterface

`default_nettype wire

//--- src/fp_result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fp_result_if;
  import fpu_pkg::*;

  logic   valid;
  float_t value;  // zero for compares
  logic   lt;     // flags low for arithmetic
  logic   le;
  logic   eq;

  modport source (
    output valid,
    output value,
    output lt,
    output le,
    output eq
  );

  modport sink (
    input valid,
    input value,
    input lt,
    input le,
    input eq
  );

endinterface

`default_nettype wire

//--- src/fp_issue.sv
`timescale 1ns/1ps
`default_nettype none

module fp_issue (
  input  logic             clk,
  input  logic             rst,
  input  logic             start_i,
  input  fpu_pkg::fpu_op_t op_i,
  input  fpu_pkg::float_t  a_i,
  input  fpu_pkg::float_t  b_i,
  fp_issue_if.issue        iss
);

  // strobe becomes the first pipeline stage
  always_ff @(posedge clk) begin
    if (rst) begin
      iss.valid <= 1'b0;
    end else begin
      iss.valid <= start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      iss.op <= op_i;
      iss.a  <= a_i;
      iss.b  <= b_i;
    end
  end

endmodule

`default_nettype wire

//--- src/fp_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module fp_addsub (
  input  logic        clk,
  input  logic        rst,
  fp_issue_if.unit    iss,
  fp_result_if.source res
);
  import fpu_pkg::*;

  localparam int MANT_W = MAN_W + 1;  // with hidden one
  localparam int LZ_W   = $clog2(MANT_W);

  logic              take;
  logic [MANT_W-1:0] a_mant;
  logic [MANT_W-1:0] b_mant;
  logic [EXP_W-1:0]  exp_diff;
  logic [EXP_W-1:0]  exp_max_d;
  logic [MANT_W-1:0] a_al_d;
  logic [MANT_W-1:0] b_al_d;

  // stage 1 registers
  logic              s1_vld;
  logic [MANT_W-1:0] s1_a;
  logic [MANT_W-1:0] s1_b;
  logic [EXP_W-1:0]  s1_exp;
  logic              s1_sa;
  logic              s1_sb;
  logic              s1_a_gt;
  fpu_op_t           s1_op;

  logic              eff_sub;
  logic              b_sign_eff;
  logic [MANT_W:0]   mag_d;
  logic              sign_d;

  // stage 2 registers
  logic              s2_vld;
  logic [MANT_W:0]   s2_mag;
  logic [EXP_W-1:0]  s2_exp;
  logic              s2_sign;

  logic [LZ_W-1:0]   lead_zeros;
  logic [MANT_W-1:0] norm_mag;
  float_t            norm_d;

  // stage 3 registers
  logic              s3_vld;
  float_t            s3_word;

  assign take   = iss.valid && (iss.op == OP_ADD || iss.op == OP_SUB);
  assign a_mant = {1'b1, iss.a.man};
  assign b_mant = {1'b1, iss.b.man};

  // align smaller operand to the larger exponent, truncating
  always_comb begin
    if (iss.a.exp >= iss.b.exp) begin
      exp_diff  = iss.a.exp - iss.b.exp;
      exp_max_d = iss.a.exp;
      a_al_d    = a_mant;
      b_al_d    = b_mant >> exp_diff;
    end else begin
      exp_diff  = iss.b.exp - iss.a.exp;
      exp_max_d = iss.b.exp;
      a_al_d    = a_mant >> exp_diff;
      b_al_d    = b_mant;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      s3_vld <= 1'b0;
    end else begin
      s1_vld <= take;
      s2_vld <= s1_vld;
      s3_vld <= s2_vld;
    end
  end

  always_ff @(posedge clk) begin
    s1_a    <= a_al_d;
    s1_b    <= b_al_d;
    s1_exp  <= exp_max_d;
    s1_sa   <= iss.a.sign;
    s1_sb   <= iss.b.sign;
    s1_a_gt <= {iss.a.exp, iss.a.man} > {iss.b.exp, iss.b.man};
    s1_op   <= iss.op;
  end

  // sub flips the sign of b
  assign eff_sub    = (s1_op == OP_SUB) ? (s1_sa == s1_sb) : (s1_sa != s1_sb);
  assign b_sign_eff = (s1_op == OP_SUB) ? ~s1_sb : s1_sb;

  always_comb begin
    if (!eff_sub) begin
      mag_d  = {1'b0, s1_a} + {1'b0, s1_b};
      sign_d = s1_sa;
    end else if (s1_a_gt) begin
      mag_d  = {1'b0, s1_a} - {1'b0, s1_b};
      sign_d = s1_sa;
    end else begin
      mag_d  = {1'b0, s1_b} - {1'b0, s1_a};  // equal gives zero
      sign_d = b_sign_eff;
    end
  end

  always_ff @(posedge clk) begin
    s2_mag  <= mag_d;
    s2_exp  <= s1_exp;
    s2_sign <= sign_d;
  end

  // leading one search, highest set bit wins
  always_comb begin
    lead_zeros = '0;
    for (int i = 0; i < MANT_W; i++) begin
      if (s2_mag[i]) begin
        lead_zeros = LZ_W'(MANT_W - 1 - i);
      end
    end
  end

  assign norm_mag = s2_mag[MANT_W-1:0] << lead_zeros;

  always_comb begin
    norm_d.sign = s2_sign;
    if (s2_mag[MANT_W]) begin
      norm_d.exp = s2_exp + 1'b1;  // carry out
      norm_d.man = s2_mag[MANT_W-1:1];
    end else begin
      norm_d.exp = s2_exp - lead_zeros;
      norm_d.man = norm_mag[MAN_W-1:0];
    end
    if (s2_mag == '0) begin
      norm_d = '0;
    end
  end

  always_ff @(posedge clk) begin
    s3_word <= norm_d;
  end

  assign res.valid = s3_vld;
  assign res.value = s3_word;
  assign res.lt    = 1'b0;
  assign res.le    = 1'b0;
  assign res.eq    = 1'b0;

endmodule

`default_nettype wire

//--- src/fp_multiply.sv
`timescale 1ns/1ps
`default_nettype none

module fp_multiply #(
  parameter int STAGES = 3
) (
  input  logic        clk,
  input  logic        rst,
  fp_issue_if.unit    iss,
  fp_result_if.source res
);
  import fpu_pkg::*;

  localparam int MANT_W = MAN_W + 1;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MANT_W:0]  prod;  // top bits of the product
  } mul_item_t;

  logic                take;
  logic [2*MANT_W-1:0] prod_full;
  logic [EXP_W-1:0]    exp_sum;
  mul_item_t           item_d;
  mul_item_t           chain_q [STAGES];
  logic [STAGES-1:0]   vld_q;
  mul_item_t           tail;
  float_t              norm;

  assign take      = iss.valid && (iss.op == OP_MUL);
  assign prod_full = {1'b1, iss.a.man} * {1'b1, iss.b.man};
  assign exp_sum   = iss.a.exp + iss.b.exp - EXP_W'(EXP_BIAS);

  assign item_d.sign = iss.a.sign ^ iss.b.sign;
  assign item_d.exp  = exp_sum;
  assign item_d.prod = prod_full[2*MANT_W-1:MAN_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= take;
      for (int i = 1; i < STAGES; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    chain_q[0] <= item_d;
    for (int i = 1; i < STAGES; i++) begin
      chain_q[i] <= chain_q[i-1];
    end
  end

  assign tail = chain_q[STAGES-1];

  // product in [1,4), at most one right shift
  always_comb begin
    norm.sign = tail.sign;
    if (tail.prod[MANT_W]) begin
      norm.exp = tail.exp + 1'b1;
      norm.man = tail.prod[MANT_W-1:1];
    end else begin
      norm.exp = tail.exp;
      norm.man = tail.prod[MAN_W-1:0];
    end
  end

  assign res.valid = vld_q[STAGES-1];
  assign res.value = norm;
  assign res.lt    = 1'b0;
  assign res.le    = 1'b0;
  assign res.eq    = 1'b0;

endmodule

`default_nettype wire

//--- src/fp_compare.sv
`timescale 1ns/1ps
`default_nettype none

module fp_compare #(
  parameter int STAGES = 3
) (
  input  logic        clk,
  input  logic        rst,
  fp_issue_if.unit    iss,
  fp_result_if.source res
);
  import fpu_pkg::*;

  logic                     take;
  logic [FLOAT_W-2:0]       mag_a;
  logic [FLOAT_W-2:0]       mag_b;
  logic                     lt_d;
  logic                     eq_d;
  logic [2:0]               flags_q [STAGES];  // lt, le, eq
  logic [STAGES-1:0]        vld_q;

  assign take  = iss.valid && (iss.op == OP_CMP);
  assign mag_a = {iss.a.exp, iss.a.man};
  assign mag_b = {iss.b.exp, iss.b.man};

  always_comb begin
    if (mag_a == '0 && mag_b == '0) begin
      lt_d = 1'b0;  // +0 == -0
      eq_d = 1'b1;
    end else if (iss.a.sign != iss.b.sign) begin
      lt_d = iss.a.sign;
      eq_d = 1'b0;
    end else if (iss.a.sign) begin
      lt_d = mag_b < mag_a;  // both negative, order reversed
      eq_d = mag_a == mag_b;
    end else begin
      lt_d = mag_a < mag_b;
      eq_d = mag_a == mag_b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= take;
      for (int i = 1; i < STAGES; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    flags_q[0] <= {lt_d, lt_d | eq_d, eq_d};
    for (int i = 1; i < STAGES; i++) begin
      flags_q[i] <= flags_q[i-1];
    end
  end

  assign res.valid = vld_q[STAGES-1];
  assign res.value = '0;
  assign res.lt    = flags_q[STAGES-1][2];
  assign res.le    = flags_q[STAGES-1][1];
  assign res.eq    = flags_q[STAGES-1][0];

endmodule

`default_nettype wire

//--- src/fp_retire.sv
`timescale 1ns/1ps
`default_nettype none

module fp_retire (
  input  logic            clk,
  input  logic            rst,
  fp_result_if.sink       add_res,
  fp_result_if.sink       mul_res,
  fp_result_if.sink       cmp_res,
  output logic            result_valid_o,
  output fpu_pkg::float_t result_o,
  output logic            lt_o,
  output logic            le_o,
  output logic            eq_o
);
  import fpu_pkg::*;

  logic   any_valid;
  float_t sel_value;
  logic   sel_lt;
  logic   sel_le;
  logic   sel_eq;

  assign any_valid = add_res.valid | mul_res.valid | cmp_res.valid;

  // equal depths, so at most one source per cycle
  always_comb begin
    sel_value = '0;
    sel_lt    = 1'b0;
    sel_le    = 1'b0;
    sel_eq    = 1'b0;
    if (add_res.valid) begin
      sel_value = add_res.value;
      sel_lt    = add_res.lt;
      sel_le    = add_res.le;
      sel_eq    = add_res.eq;
    end else if (mul_res.valid) begin
      sel_value = mul_res.value;
      sel_lt    = mul_res.lt;
      sel_le    = mul_res.le;
      sel_eq    = mul_res.eq;
    end else if (cmp_res.valid) begin
      sel_value = cmp_res.value;
      sel_lt    = cmp_res.lt;
      sel_le    = cmp_res.le;
      sel_eq    = cmp_res.eq;
    end
  end

  // idle cycles clear the outputs
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
      lt_o           <= 1'b0;
      le_o           <= 1'b0;
      eq_o           <= 1'b0;
    end else begin
      result_valid_o <= any_valid;
      result_o       <= sel_value;
      lt_o           <= sel_lt;
      le_o           <= sel_le;
      eq_o           <= sel_eq;
    end
  end

endmodule

`default_nettype wire

//--- src/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start_i,
  input  logic [1:0]                  op_i,
  input  logic [fpu_pkg::FLOAT_W-1:0] a_i,
  input  logic [fpu_pkg::FLOAT_W-1:0] b_i,
  output logic                        result_valid_o,
  output logic [fpu_pkg::FLOAT_W-1:0] result_o,
  output logic                        lt_o,
  output logic                        le_o,
  output logic                        eq_o
);
  import fpu_pkg::*;

  fp_issue_if  iss_if ();
  fp_result_if add_if ();
  fp_result_if mul_if ();
  fp_result_if cmp_if ();

  fp_issue i_issue (
    .clk     (clk),
    .rst     (rst),
    .start_i (start_i),
    .op_i    (fpu_op_t'(op_i)),
    .a_i     (a_i),
    .b_i     (b_i),
    .iss     (iss_if.issue)
  );

  fp_addsub i_addsub (
    .clk (clk),
    .rst (rst),
    .iss (iss_if.unit),
    .res (add_if.source)
  );

  // depth matched to the addsub pipeline
  fp_multiply #(
    .STAGES (PIPE_DEPTH)
  ) i_multiply (
    .clk (clk),
    .rst (rst),
    .iss (iss_if.unit),
    .res (mul_if.source)
  );

  fp_compare #(
    .STAGES (PIPE_DEPTH)
  ) i_compare (
    .clk (clk),
    .rst (rst),
    .iss (iss_if.unit),
    .res (cmp_if.source)
  );

  fp_retire i_retire (
    .clk            (clk),
    .rst            (rst),
    .add_res        (add_if.sink),
    .mul_res        (mul_if.sink),
    .cmp_res        (cmp_if.sink),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .lt_o           (lt_o),
    .le_o           (le_o),
    .eq_o           (eq_o)
  );

endmodule

`default_nettype wire

//--- testbench/fpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_asserts (
  input logic clk,
  input logic rst,
  input logic iss_valid,
  input logic add_valid,
  input logic mul_valid,
  input logic cmp_valid,
  input logic result_valid
);
  import fpu_pkg::*;

  // equal unit depths keep results apart
  a_one_source: assert property (@(posedge clk) disable iff (rst)
    $onehot0({add_valid, mul_valid, cmp_valid}))
    else $error("more than one unit result valid in one cycle");

  a_reset_quiet: assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid_o high during reset");

  a_latency: assert property (@(posedge clk) disable iff (rst)
    iss_valid |-> ##(PIPE_DEPTH + 1) result_valid)
    else $error("issued operation did not retire after the fixed depth");

endmodule

bind fpu_top fpu_asserts i_asserts (
  .clk          (clk),
  .rst          (rst),
  .iss_valid    (iss_if.valid),
  .add_valid    (add_if.valid),
  .mul_valid    (mul_if.valid),
  .cmp_valid    (cmp_if.valid),
  .result_valid (result_valid_o)
);

`default_nettype wire

//--- testbench/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
  import fpu_pkg::*;

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 10;
  localparam int N_ADDSUB     = 200;
  localparam int N_CANCEL     = 60;
  localparam int N_MUL        = 200;
  localparam int N_CMP        = 100;
  localparam int N_STREAM     = 240;
  localparam int N_DIRECTED   = 12;
  localparam int TOTAL_OPS    = N_ADDSUB + N_CANCEL + N_MUL + N_CMP + N_STREAM + N_DIRECTED;
  localparam int MARGIN       = 200;
  // gapped groups take two cycles per operation
  localparam int WATCHDOG_CYCLES = 2 * TOTAL_OPS + RESET_CYCLES + LATENCY + MARGIN;

  logic        clk;
  logic        rst;
  logic        start_i;
  logic [1:0]  op_i;
  logic [31:0] a_i;
  logic [31:0] b_i;
  logic        result_valid_o;
  logic [31:0] result_o;
  logic        lt_o;
  logic        le_o;
  logic        eq_o;

  logic [31:0] lfsr_state;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          due_q[$];   // cycle each result is expected
  logic [34:0] exp_q[$];   // {word, lt, le, eq}
  string       name_q[$];

  fpu_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .start_i        (start_i),
    .op_i           (op_i),
    .a_i            (a_i),
    .b_i            (b_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .lt_o           (lt_o),
    .le_o           (le_o),
    .eq_o           (eq_o)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // exponent kept in 64..190
  task automatic rand_float(output logic [31:0] f);
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] m;
    take_bits(1, s);
    take_bits(7, e);
    take_bits(23, m);
    f = {s[0], 8'(64 + e % 127), m[22:0]};
  endtask

  // zeros share one key and negatives sort below positives
  function automatic logic [31:0] order_key(input logic [31:0] f);
    if (f[30:0] == '0) begin
      return {1'b1, 31'b0};
    end else if (f[31]) begin
      return {1'b0, ~f[30:0]};
    end
    return {1'b1, f[30:0]};
  endfunction

  function automatic logic [34:0] ref_result(input logic [1:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [24:0] ma;
    logic [24:0] mb;
    logic [24:0] mag;
    logic [7:0]  ex;
    logic        sb;
    logic        sgn;
    logic [47:0] prod;
    logic        lt;
    logic        eq;
    if (op == OP_MUL) begin
      prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};
      ex   = 8'(a[30:23] + b[30:23] - 127);
      sgn  = a[31] ^ b[31];
      if (prod[47]) begin
        return {sgn, ex + 8'd1, prod[46:24], 3'b000};
      end
      return {sgn, ex, prod[45:23], 3'b000};
    end else if (op == OP_CMP) begin
      lt = order_key(a) < order_key(b);
      eq = order_key(a) == order_key(b);
      return {32'b0, lt, lt | eq, eq};
    end
    ma = {2'b01, a[22:0]};
    mb = {2'b01, b[22:0]};
    if (a[30:23] >= b[30:23]) begin
      ex = a[30:23];
      mb = mb >> (a[30:23] - b[30:23]);
    end else begin
      ex = b[30:23];
      ma = ma >> (b[30:23] - a[30:23]);
    end
    sb = (op == OP_SUB) ? ~b[31] : b[31];
    if (a[31] == sb) begin
      mag = ma + mb;
      sgn = a[31];
    end else if (a[30:0] > b[30:0]) begin
      mag = ma - mb;
      sgn = a[31];
    end else begin
      mag = mb - ma;
      sgn = sb;
    end
    if (mag == '0) begin
      return '0;
    end
    if (mag[24]) begin
      return {sgn, ex + 8'd1, mag[23:1], 3'b000};
    end
    while (!mag[23]) begin
      mag = mag << 1;
      ex  = ex - 8'd1;
    end
    return {sgn, ex, mag[22:0], 3'b000};
  endfunction

  task automatic check_value(input string name, input logic [34:0] expected,
                             input logic [34:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
  endtask

  // called 2 ns after an edge and returns one cycle later with start low
  task automatic issue_op(input string name, input logic [1:0] op, input logic [31:0] a,
                          input logic [31:0] b);
    start_i = 1'b1;
    op_i    = op;
    a_i     = a;
    b_i     = b;
    due_q.push_back(cyc + LATENCY);
    exp_q.push_back(ref_result(op, a, b));
    name_q.push_back(name);
    idle_cycle();
    start_i = 1'b0;
  endtask

  task automatic drain();
    while (due_q.size() != 0) begin
      idle_cycle();
    end
    idle_cycle();
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      if (result_valid_o) begin
        if (due_q.size() == 0) begin
          errors++;
          $display("ERROR: result_valid_o high at cycle %0d with no operation due", cyc);
        end else begin
          if (due_q[0] != cyc) begin
            errors++;
            $display("ERROR: %s retired at cycle %0d but was due at cycle %0d",
                     name_q[0], cyc, due_q[0]);
          end
          check_value(name_q[0], exp_q[0], {result_o, lt_o, le_o, eq_o});
          void'(due_q.pop_front());
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
        end
      end else begin
        check_value("idle outputs", '0, {result_o, lt_o, le_o, eq_o});
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
          errors++;
          $display("ERROR: %s was due at cycle %0d but no result came", name_q[0], due_q[0]);
          void'(due_q.pop_front());
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
             WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    lfsr_state = 32'h1aff;
    rst     = 1'b1;
    start_i = 1'b0;
    op_i    = 2'd0;
    a_i     = '0;
    b_i     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    check_value("reset", '0, {result_o, lt_o, le_o, eq_o});
    repeat (4) idle_cycle();

    for (int i = 0; i < N_ADDSUB; i++) begin
      rand_float(a);
      rand_float(b);
      take_bits(1, r);
      issue_op($sformatf("addsub %0d", i), r[0] ? OP_SUB : OP_ADD, a, b);
      idle_cycle();
    end
    // b differs from a only in the low bits for long cancellation
    for (int i = 0; i < N_CANCEL; i++) begin
      rand_float(a);
      take_bits(9, r);
      b = {a[31] ^ r[8], a[30:8], r[7:0]};
      issue_op($sformatf("cancel %0d", i), r[8] ? OP_ADD : OP_SUB, a, b);
      idle_cycle();
    end
    for (int i = 0; i < 2; i++) begin
      rand_float(a);
      issue_op("exact sub", OP_SUB, a, a);
      issue_op("exact add", OP_ADD, a, {~a[31], a[30:0]});
    end
    drain();

    for (int i = 0; i < N_MUL; i++) begin
      rand_float(a);
      rand_float(b);
      issue_op($sformatf("mul %0d", i), OP_MUL, a, b);
      idle_cycle();
    end
    drain();

    issue_op("cmp +0 -0", OP_CMP, 32'h0000_0000, 32'h8000_0000);
    issue_op("cmp -0 +0", OP_CMP, 32'h8000_0000, 32'h0000_0000);
    issue_op("cmp 1 1", OP_CMP, 32'h3f80_0000, 32'h3f80_0000);
    issue_op("cmp -2 -2", OP_CMP, 32'hc000_0000, 32'hc000_0000);
    issue_op("cmp -1 -2", OP_CMP, 32'hbf80_0000, 32'hc000_0000);
    issue_op("cmp -2 -1", OP_CMP, 32'hc000_0000, 32'hbf80_0000);
    issue_op("cmp 1 -1", OP_CMP, 32'h3f80_0000, 32'hbf80_0000);
    issue_op("cmp -1 1", OP_CMP, 32'hbf80_0000, 32'h3f80_0000);
    for (int i = 0; i < N_CMP; i++) begin
      rand_float(a);
      rand_float(b);
      take_bits(2, r);
      if (r[1:0] == 2'd0) begin
        b = a;  // hit the equal case often
      end
      issue_op($sformatf("cmp %0d", i), OP_CMP, a, b);
      idle_cycle();
    end
    drain();

    // start_i high every cycle
    for (int i = 0; i < N_STREAM; i++) begin
      rand_float(a);
      rand_float(b);
      take_bits(2, r);
      issue_op($sformatf("stream %0d", i), r[1:0], a, b);
      start_i = 1'b1;
    end
    start_i = 1'b0;
    drain();
    repeat (LATENCY + 2) idle_cycle();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/fpu_pkg.sv
src/fp_issue_if.sv
src/fp_result_if.sv
src/fp_issue.sv
src/fp_addsub.sv
src/fp_multiply.sv
src/fp_compare.sv
src/fp_retire.sv
src/fpu_top.sv
testbench/fpu_asserts.sv
testbench/fpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fpu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module fpu_tb -f project.f -Mdir "$OBJ" -o fpu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ/fpu_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
